/* lsu.f */
src/lsu_pkg.sv
src/apb_if.sv
src/lsu_mem1.sv
src/lsu_apb_master.sv
src/data_ram.sv
src/lsu_mem2.sv
src/lsu_top.sv
tests/lsu_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f lsu.f --top-module lsu_tb -o lsu_sim

out=$(./obj_dir/lsu_sim || true)
echo "$out"

if echo "$out" | grep -q "^Test OK$"; then
    exit 0
fi
echo "simulation did not pass"
exit 1

/* tests/lsu_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module lsu_tb
    import lsu_pkg::*;
();
    // directed requests in tests 1 to 4 are 8, 13, 14 and 14
    localparam int N_DIRECTED = 49;
    localparam int N_RANDOM   = 300;
    localparam int MAX_CYCLES = (N_DIRECTED + N_RANDOM) * 12 + 200;
    localparam logic [31:0] SEED = 32'hbedb_f515;

    logic              clk;
    logic              rst;
    logic              req_valid_i;
    mem_op_e           req_op_i;
    logic [ADDR_W-1:0] req_addr_i;
    logic [DATA_W-1:0] req_wdata_i;
    logic [REG_W-1:0]  req_rd_i;
    logic              req_ready_o;
    logic              wb_ready_i;
    logic              wb_valid_o;
    logic              wb_wreg_o;
    logic [REG_W-1:0]  wb_rd_o;
    logic [DATA_W-1:0] wb_data_o;
    logic              wb_err_o;
    logic              fwd_valid_o;
    logic [REG_W-1:0]  fwd_rd_o;
    logic [DATA_W-1:0] fwd_data_o;

    logic [DATA_W-1:0] model [RAM_WORDS];
    wb_t               exp_q [$];
    wb_t               got;
    wb_t               exp_head;
    int                fwd_idx;
    int                cycles;
    int                wb_errs;
    int                fwd_errs;
    int                fwd_checks;
    int                wb_pops;
    int                last_fwd_seq;
    int                fwd_entries;
    int                wreg_wbs;
    int                tests_passed;
    int                tests_failed;
    int                test_no;
    int                errs_at_start;
    logic              stall_en;
    logic [31:0]       stim_rnd;
    logic [31:0]       ready_rnd;
    mem_op_e           rnd_op;
    logic [ADDR_W-1:0] rnd_addr;

    lsu_top uut (
        .clk         (clk),
        .rst         (rst),
        .req_valid_i (req_valid_i),
        .req_op_i    (req_op_i),
        .req_addr_i  (req_addr_i),
        .req_wdata_i (req_wdata_i),
        .req_rd_i    (req_rd_i),
        .req_ready_o (req_ready_o),
        .wb_ready_i  (wb_ready_i),
        .wb_valid_o  (wb_valid_o),
        .wb_wreg_o   (wb_wreg_o),
        .wb_rd_o     (wb_rd_o),
        .wb_data_o   (wb_data_o),
        .wb_err_o    (wb_err_o),
        .fwd_valid_o (fwd_valid_o),
        .fwd_rd_o    (fwd_rd_o),
        .fwd_data_o  (fwd_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // expected write-back for one request and the memory word after it
    function automatic wb_t expect_result(input mem_op_e op, input logic [ADDR_W-1:0] addr,
                                          input logic [DATA_W-1:0] wdata,
                                          input logic [REG_W-1:0] rd,
                                          input logic [DATA_W-1:0] word,
                                          output logic [DATA_W-1:0] new_word);
        wb_t         r;
        logic        is_load;
        logic        bad;
        logic [7:0]  b;
        logic [15:0] h;
        is_load = op inside {OP_LD_B, OP_LD_H, OP_LD_W, OP_LD_BU, OP_LD_HU};
        bad = (op inside {OP_LD_H, OP_LD_HU, OP_ST_H}) ? addr[0] :
              (op inside {OP_LD_W, OP_ST_W}) ? (addr[1:0] != 2'b00) : 1'b0;
        b = 8'(word >> (8 * addr[1:0]));
        h = 16'(word >> (16 * addr[1]));
        new_word = word;
        r.valid = 1'b1;
        r.rd    = rd;
        r.err   = bad;
        r.wreg  = is_load && !bad;
        r.data  = '0;
        if (!bad) begin
            case (op)
                OP_LD_B:  r.data = {{24{b[7]}}, b};
                OP_LD_BU: r.data = {24'd0, b};
                OP_LD_H:  r.data = {{16{h[15]}}, h};
                OP_LD_HU: r.data = {16'd0, h};
                OP_LD_W:  r.data = word;
                OP_ST_B:  new_word[8*addr[1:0] +: 8] = wdata[7:0];
                OP_ST_H:  new_word[16*addr[1] +: 16] = wdata[15:0];
                OP_ST_W:  new_word = wdata;
                default:  r.data = '0;
            endcase
        end
        return r;
    endfunction

    task automatic check_wb(input wb_t got_wb, input wb_t exp_wb);
        if (got_wb.wreg !== exp_wb.wreg || got_wb.rd !== exp_wb.rd ||
            got_wb.err !== exp_wb.err || got_wb.data !== exp_wb.data) begin
            wb_errs++;
            $display(
                "[ERROR] %0t: wb rd/wreg/err/data %0d/%0b/%0b/%h, expected %0d/%0b/%0b/%h",
                $time, got_wb.rd, got_wb.wreg, got_wb.err, got_wb.data,
                exp_wb.rd, exp_wb.wreg, exp_wb.err, exp_wb.data);
        end
    endtask

    task automatic check_fwd(input logic [REG_W-1:0] rd, input logic [DATA_W-1:0] data,
                             input wb_t exp_wb);
        fwd_checks++;
        if (!exp_wb.wreg || rd !== exp_wb.rd || data !== exp_wb.data) begin
            fwd_errs++;
            $display("[ERROR] %0t: fwd rd/data %0d/%h, next write-back wreg/rd/data %0b/%0d/%h",
                     $time, rd, data, exp_wb.wreg, exp_wb.rd, exp_wb.data);
        end
    endtask

    // outputs are sampled mid-cycle when they have settled
    always @(negedge clk) begin
        if (!rst) begin
            if (fwd_valid_o) begin
                fwd_idx = wb_valid_o ? 1 : 0;
                if (exp_q.size() > fwd_idx) begin
                    check_fwd(fwd_rd_o, fwd_data_o, exp_q[fwd_idx]);
                    // count each forwarded entry once
                    if (wb_pops + fwd_idx != last_fwd_seq) begin
                        fwd_entries++;
                        last_fwd_seq = wb_pops + fwd_idx;
                    end
                end else begin
                    fwd_errs++;
                    $display("forwarding output was valid while no request was pending");
                end
            end
            if (wb_valid_o && wb_ready_i) begin
                got = {wb_valid_o, wb_wreg_o, wb_rd_o, wb_data_o, wb_err_o};
                if (exp_q.size() == 0) begin
                    wb_errs++;
                    $display("a write-back entry appeared that no request had asked for");
                end else begin
                    exp_head = exp_q.pop_front();
                    wb_pops++;
                    if (exp_head.wreg) begin
                        wreg_wbs++;
                    end
                    check_wb(got, exp_head);
                end
            end
        end
    end

    // random write-back stalls while the stream runs
    initial begin
        ready_rnd = ~SEED;
        forever begin
            @(posedge clk);
            if (stall_en) begin
                ready_rnd = xorshift(ready_rnd);
                if (ready_rnd[3:0] == 4'd0) begin
                    wb_ready_i <= 1'b0;
                    repeat (int'(ready_rnd[6:4]) + 1) @(posedge clk);
                    wb_ready_i <= 1'b1;
                end
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    task automatic send(input mem_op_e op, input logic [ADDR_W-1:0] addr,
                        input logic [DATA_W-1:0] wdata, input logic [REG_W-1:0] rd);
        logic [DATA_W-1:0] new_word;
        wb_t               exp_wb;
        @(posedge clk);
        req_valid_i <= 1'b1;
        req_op_i    <= op;
        req_addr_i  <= addr;
        req_wdata_i <= wdata;
        req_rd_i    <= rd;
        @(negedge clk);
        while (!req_ready_o) @(negedge clk);
        // accepted at the coming edge
        exp_wb = expect_result(op, addr, wdata, rd, model[addr[ADDR_W-1:2]], new_word);
        model[addr[ADDR_W-1:2]] = new_word;
        exp_q.push_back(exp_wb);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            req_valid_i <= 1'b0;
        end
    endtask

    task automatic start_test();
        test_no++;
        errs_at_start = wb_errs;
    endtask

    task automatic finish_test(input string name);
        idle(1);
        while (exp_q.size() != 0) @(negedge clk);
        if (wb_errs == errs_at_start) begin
            tests_passed++;
            $display("test %0d %s: passed", test_no, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", test_no, name, wb_errs - errs_at_start);
        end
    endtask

    initial begin
        rst          = 1'b1;
        req_valid_i  = 1'b0;
        req_op_i     = OP_LD_W;
        req_addr_i   = '0;
        req_wdata_i  = '0;
        req_rd_i     = '0;
        wb_ready_i   = 1'b1;
        stall_en     = 1'b0;
        stim_rnd     = SEED;
        wb_errs      = 0;
        fwd_errs     = 0;
        fwd_checks   = 0;
        wb_pops      = 0;
        last_fwd_seq = -1;
        fwd_entries  = 0;
        wreg_wbs     = 0;
        tests_passed = 0;
        tests_failed = 0;
        test_no      = 0;
        for (int i = 0; i < RAM_WORDS; i++) begin
            model[i] = '0;
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // addresses 0x40..0x4c cover all four wait-state counts
        start_test();
        for (int i = 0; i < 4; i++) begin
            send(OP_ST_W, 12'h040 + 12'(4 * i), 32'hdead_beef + 32'(i) * 32'h1111_1111, 5'(i));
            send(OP_LD_W, 12'h040 + 12'(4 * i), '0, 5'(i + 8));
        end
        finish_test("word store and load");

        start_test();
        send(OP_ST_W, 12'h100, 32'hf08c_7a35, 5'd1);
        for (int i = 0; i < 4; i++) begin
            send(OP_LD_B, 12'h100 + 12'(i), '0, 5'(i + 2));
            send(OP_LD_BU, 12'h100 + 12'(i), '0, 5'(i + 10));
        end
        for (int i = 0; i < 2; i++) begin
            send(OP_LD_H, 12'h100 + 12'(2 * i), '0, 5'(i + 20));
            send(OP_LD_HU, 12'h100 + 12'(2 * i), '0, 5'(i + 24));
        end
        finish_test("byte and half loads");

        start_test();
        send(OP_ST_W, 12'h200, 32'h1122_3344, 5'd3);
        for (int i = 0; i < 4; i++) begin
            send(OP_ST_B, 12'h200 + 12'(i), 32'h5a5a_5a00 | 32'(i + 1), 5'd3);
            send(OP_LD_W, 12'h200, '0, 5'(i + 4));
        end
        send(OP_ST_W, 12'h204, 32'h5566_7788, 5'd3);
        for (int i = 0; i < 2; i++) begin
            send(OP_ST_H, 12'h204 + 12'(2 * i), 32'hbeef_1234 + 32'(i), 5'd3);
            send(OP_LD_W, 12'h204, '0, 5'(i + 12));
        end
        finish_test("byte and half stores");

        start_test();
        send(OP_ST_W, 12'h300, 32'h1357_9bdf, 5'd6);
        for (int off = 1; off < 4; off++) begin
            send(OP_LD_W, 12'h300 + 12'(off), '0, 5'd7);
            send(OP_ST_W, 12'h300 + 12'(off), 32'hffff_ffff, 5'd8);
        end
        for (int off = 1; off < 4; off += 2) begin
            send(OP_LD_H, 12'h300 + 12'(off), '0, 5'd7);
            send(OP_LD_HU, 12'h300 + 12'(off), '0, 5'd7);
            send(OP_ST_H, 12'h300 + 12'(off), 32'hffff_ffff, 5'd8);
        end
        send(OP_LD_W, 12'h300, '0, 5'd9);
        finish_test("misaligned accesses");

        // random ops on 16 words so loads often hit earlier stores
        start_test();
        stall_en = 1'b1;
        for (int n = 0; n < N_RANDOM; n++) begin
            stim_rnd = xorshift(stim_rnd);
            rnd_op   = mem_op_e'({1'b0, stim_rnd[2:0]});
            rnd_addr = 12'h100 | {6'd0, stim_rnd[6:3], stim_rnd[8:7]};
            send(rnd_op, rnd_addr, xorshift(stim_rnd), stim_rnd[13:9]);
            if (stim_rnd[15:14] == 2'd0) begin
                idle(int'(stim_rnd[17:16]) + 1);
            end
        end
        stall_en = 1'b0;
        finish_test("random stream");

        // every load that was written back must have been forwarded first
        test_no++;
        if (fwd_errs == 0 && fwd_entries == wreg_wbs) begin
            tests_passed++;
            $display("test %0d forwarding: passed, %0d checks", test_no, fwd_checks);
        end else begin
            tests_failed++;
            $display("test %0d forwarding: failed, %0d errors, %0d of %0d loads forwarded",
                     test_no, fwd_errs, fwd_entries, wreg_wbs);
        end

        if (exp_q.size() != 0) begin
            $display("%0d expected write-back entries never appeared", exp_q.size());
        end
        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && exp_q.size() == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/lsu_top.sv */
`timescale 1ns/1ns
`default_nettype none

module lsu_top
    import lsu_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,

    input  wire logic              req_valid_i,
    input  wire mem_op_e           req_op_i,
    input  wire logic [ADDR_W-1:0] req_addr_i,
    input  wire logic [DATA_W-1:0] req_wdata_i,
    input  wire logic [REG_W-1:0]  req_rd_i,
    output logic                   req_ready_o,

    input  wire logic              wb_ready_i,
    output logic                   wb_valid_o,
    output logic                   wb_wreg_o,
    output logic [REG_W-1:0]       wb_rd_o,
    output logic [DATA_W-1:0]      wb_data_o,
    output logic                   wb_err_o,

    output logic                   fwd_valid_o,
    output logic [REG_W-1:0]       fwd_rd_o,
    output logic [DATA_W-1:0]      fwd_data_o
);
    mem1_mem2_t        mem1_q;
    wb_t               wb;
    logic              advance;
    logic              advance_ready;
    logic              issue;
    logic [ADDR_W-1:0] issue_addr;
    logic              issue_write;
    logic [DATA_W-1:0] issue_wdata;
    logic [STRB_W-1:0] issue_strb;
    logic              data_ok;
    logic [DATA_W-1:0] rdata;

    apb_if bus ();

    lsu_mem1 u_mem1 (
        .clk             (clk),
        .rst             (rst),
        .req_valid_i     (req_valid_i),
        .req_op_i        (req_op_i),
        .req_addr_i      (req_addr_i),
        .req_wdata_i     (req_wdata_i),
        .req_rd_i        (req_rd_i),
        .req_ready_o     (req_ready_o),
        .advance_i       (advance),
        .advance_ready_i (advance_ready),
        .issue_o         (issue),
        .issue_addr_o    (issue_addr),
        .issue_write_o   (issue_write),
        .issue_wdata_o   (issue_wdata),
        .issue_strb_o    (issue_strb),
        .mem1_o          (mem1_q)
    );

    lsu_apb_master u_master (
        .clk           (clk),
        .rst           (rst),
        .issue_i       (issue),
        .issue_addr_i  (issue_addr),
        .issue_write_i (issue_write),
        .issue_wdata_i (issue_wdata),
        .issue_strb_i  (issue_strb),
        .data_ok_o     (data_ok),
        .rdata_o       (rdata),
        .apb           (bus.master)
    );

    data_ram u_ram (
        .clk (clk),
        .rst (rst),
        .apb (bus.slave)
    );

    lsu_mem2 u_mem2 (
        .clk             (clk),
        .rst             (rst),
        .mem1_i          (mem1_q),
        .data_ok_i       (data_ok),
        .rdata_i         (rdata),
        .wb_ready_i      (wb_ready_i),
        .advance_o       (advance),
        .advance_ready_o (advance_ready),
        .fwd_valid_o     (fwd_valid_o),
        .fwd_rd_o        (fwd_rd_o),
        .fwd_data_o      (fwd_data_o),
        .wb_o            (wb)
    );

    assign wb_valid_o = wb.valid;
    assign wb_wreg_o  = wb.wreg;
    assign wb_rd_o    = wb.rd;
    assign wb_data_o  = wb.data;
    assign wb_err_o   = wb.err;

endmodule

`default_nettype wire

/* src/lsu_mem2.sv */
`timescale 1ns/1ns
`default_nettype none

module lsu_mem2
    import lsu_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,

    input  wire mem1_mem2_t        mem1_i,

    input  wire logic              data_ok_i,
    input  wire logic [DATA_W-1:0] rdata_i,

    input  wire logic              wb_ready_i,

    output logic                   advance_o,
    output logic                   advance_ready_o,

    output logic                   fwd_valid_o,
    output logic [REG_W-1:0]       fwd_rd_o,
    output logic [DATA_W-1:0]      fwd_data_o,

    output wb_t                    wb_o
);
    mem1_mem2_t        m2;
    wb_t               wb_q;
    wb_t               res;
    logic              data_already_ok;
    logic [DATA_W-1:0] rdata_delay;
    logic [DATA_W-1:0] load_word;
    logic [7:0]        byte_lane;
    logic [15:0]       half_lane;
    logic              complete;
    logic              wb_room;

    assign complete        = m2.misalign || data_ok_i || data_already_ok;
    assign wb_room         = !wb_q.valid || wb_ready_i;
    assign advance_ready_o = !m2.valid || (complete && wb_room);
    assign advance_o       = advance_ready_o && (m2.valid || mem1_i.valid);

    always_ff @(posedge clk) begin
        if (rst) begin
            m2.valid <= 1'b0;
        end else if (advance_o) begin
            m2 <= mem1_i;
        end
    end

    // a response that lands while write-back is blocked is kept here
    always_ff @(posedge clk) begin
        if (rst || advance_o) begin
            data_already_ok <= 1'b0;
            rdata_delay     <= '0;
        end else if (data_ok_i) begin
            data_already_ok <= 1'b1;
            rdata_delay     <= rdata_i;
        end
    end

    assign load_word = rdata_delay | rdata_i;
    assign byte_lane = load_word[{m2.addr[1:0], 3'b000} +: 8];
    assign half_lane = m2.addr[1] ? load_word[31:16] : load_word[15:0];

    always_comb begin
        res.valid = m2.valid;
        res.rd    = m2.rd;
        res.err   = m2.misalign;
        res.wreg  = op_is_load(m2.op) && !m2.misalign;
        res.data  = '0;
        if (res.wreg) begin
            case (m2.op)
                OP_LD_B:  res.data = {{(DATA_W-8){byte_lane[7]}}, byte_lane};
                OP_LD_BU: res.data = {{(DATA_W-8){1'b0}}, byte_lane};
                OP_LD_H:  res.data = {{(DATA_W-16){half_lane[15]}}, half_lane};
                OP_LD_HU: res.data = {{(DATA_W-16){1'b0}}, half_lane};
                OP_LD_W:  res.data = load_word;
                default:  res.data = '0;
            endcase
        end
    end

    assign fwd_valid_o = m2.valid && complete && res.wreg;
    assign fwd_rd_o    = m2.rd;
    assign fwd_data_o  = res.data;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_q.valid <= 1'b0;
        end else if (advance_o && m2.valid) begin
            wb_q <= res;
        end else if (wb_ready_i) begin
            wb_q.valid <= 1'b0;
        end
    end

    assign wb_o = wb_q;

    // the bus only answers for an aligned entry that is still waiting
    a_data_ok_owned: assert property (@(posedge clk) disable iff (rst)
        data_ok_i |-> (m2.valid && !m2.misalign && !data_already_ok));

endmodule

`default_nettype wire

/* src/data_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module data_ram
    import lsu_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,

    apb_if.slave      apb
);
    logic [DATA_W-1:0]   mem [RAM_WORDS];
    logic [ADDR_W-3:0]   word_idx;
    logic [1:0]          wait_cnt;
    logic                setup_phase;
    logic                access_phase;

    // ram powers up cleared
    initial begin
        for (int i = 0; i < RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    assign word_idx     = apb.paddr[ADDR_W-1:2];
    assign setup_phase  = apb.psel && !apb.penable;
    assign access_phase = apb.psel && apb.penable;

    // wait states follow address bits [3:2]
    always_ff @(posedge clk) begin
        if (rst) begin
            wait_cnt <= '0;
        end else if (setup_phase) begin
            wait_cnt <= apb.paddr[3:2];
        end else if (access_phase && (wait_cnt != '0)) begin
            wait_cnt <= wait_cnt - 2'd1;
        end
    end

    assign apb.pready = access_phase && (wait_cnt == '0);

    always_ff @(posedge clk) begin
        if (apb.pready && apb.pwrite) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (apb.pstrb[b]) begin
                    mem[word_idx][8*b +: 8] <= apb.pwdata[8*b +: 8];
                end
            end
        end
    end

    assign apb.prdata = mem[word_idx];

endmodule

`default_nettype wire

/* src/lsu_apb_master.sv */
`timescale 1ns/1ns
`default_nettype none

module lsu_apb_master
    import lsu_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,

    input  wire logic              issue_i,
    input  wire logic [ADDR_W-1:0] issue_addr_i,
    input  wire logic              issue_write_i,
    input  wire logic [DATA_W-1:0] issue_wdata_i,
    input  wire logic [STRB_W-1:0] issue_strb_i,

    output logic                   data_ok_o,
    output logic [DATA_W-1:0]      rdata_o,

    apb_if.master                  apb
);
    apb_state_e        state;
    logic [ADDR_W-1:0] addr_q;
    logic              write_q;
    logic [DATA_W-1:0] wdata_q;
    logic [STRB_W-1:0] strb_q;
    logic              xfer_done;

    assign xfer_done = (state == ACCESS) && apb.pready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (issue_i) state <= SETUP;
                SETUP:   state <= ACCESS;
                ACCESS:  if (apb.pready) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue_i) begin
            addr_q  <= issue_addr_i;
            write_q <= issue_write_i;
            wdata_q <= issue_wdata_i;
            strb_q  <= issue_strb_i;
        end
    end

    // rdata_o stays zero outside the pulse so mem2 can OR it in
    always_ff @(posedge clk) begin
        if (rst) begin
            data_ok_o <= 1'b0;
            rdata_o   <= '0;
        end else begin
            data_ok_o <= xfer_done;
            rdata_o   <= xfer_done ? apb.prdata : '0;
        end
    end

    assign apb.psel    = (state != IDLE);
    assign apb.penable = (state == ACCESS);
    assign apb.paddr   = addr_q;
    assign apb.pwrite  = write_q;
    assign apb.pwdata  = wdata_q;
    assign apb.pstrb   = write_q ? strb_q : '0;

    a_issue_when_idle: assert property (@(posedge clk) disable iff (rst)
        issue_i |-> (state == IDLE));

    // address holds for the whole transfer
    a_paddr_stable: assert property (@(posedge clk) disable iff (rst)
        (apb.psel && !(apb.penable && apb.pready)) |=> (apb.psel && $stable(apb.paddr)));

endmodule

`default_nettype wire

/* src/lsu_mem1.sv */
`timescale 1ns/1ns
`default_nettype none

module lsu_mem1
    import lsu_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,

    input  wire logic              req_valid_i,
    input  wire mem_op_e           req_op_i,
    input  wire logic [ADDR_W-1:0] req_addr_i,
    input  wire logic [DATA_W-1:0] req_wdata_i,
    input  wire logic [REG_W-1:0]  req_rd_i,
    output logic                   req_ready_o,

    input  wire logic              advance_i,
    input  wire logic              advance_ready_i,

    output logic                   issue_o,
    output logic [ADDR_W-1:0]      issue_addr_o,
    output logic                   issue_write_o,
    output logic [DATA_W-1:0]      issue_wdata_o,
    output logic [STRB_W-1:0]      issue_strb_o,

    output mem1_mem2_t             mem1_o
);
    logic              m1_valid;
    mem_op_e           m1_op;
    logic [ADDR_W-1:0] m1_addr;
    logic [DATA_W-1:0] m1_wdata;
    logic [REG_W-1:0]  m1_rd;
    logic              misalign;

    // mem1 frees up in the same cycle its entry moves on
    assign req_ready_o = !m1_valid || advance_ready_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            m1_valid <= 1'b0;
        end else if (req_valid_i && req_ready_o) begin
            m1_valid <= 1'b1;
        end else if (advance_i) begin
            m1_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i && req_ready_o) begin
            m1_op    <= req_op_i;
            m1_addr  <= req_addr_i;
            m1_wdata <= req_wdata_i;
            m1_rd    <= req_rd_i;
        end
    end

    always_comb begin
        misalign = 1'b0;
        case (m1_op)
            OP_LD_H, OP_LD_HU, OP_ST_H: misalign = m1_addr[0];
            OP_LD_W, OP_ST_W:           misalign = |m1_addr[1:0];
            default:                    misalign = 1'b0;
        endcase
    end

    // strobes and store data moved onto the addressed byte lanes
    always_comb begin
        issue_strb_o  = '0;
        issue_wdata_o = m1_wdata;
        case (m1_op)
            OP_ST_B: begin
                issue_strb_o  = STRB_W'(4'b0001) << m1_addr[1:0];
                issue_wdata_o = m1_wdata << {m1_addr[1:0], 3'b000};
            end
            OP_ST_H: begin
                issue_strb_o  = STRB_W'(4'b0011) << {m1_addr[1], 1'b0};
                issue_wdata_o = m1_wdata << {m1_addr[1], 4'b0000};
            end
            OP_ST_W: issue_strb_o = '1;
            default: issue_strb_o = '0;
        endcase
    end

    assign issue_o       = advance_i && m1_valid && !misalign;
    assign issue_addr_o  = m1_addr;
    assign issue_write_o = !op_is_load(m1_op);

    assign mem1_o.valid    = m1_valid;
    assign mem1_o.op       = m1_op;
    assign mem1_o.addr     = m1_addr;
    assign mem1_o.rd       = m1_rd;
    assign mem1_o.misalign = misalign;

    // a misaligned store never reaches the bus with its strobes
    a_no_misaligned_issue: assert property (@(posedge clk) disable iff (rst)
        issue_o |-> ((issue_strb_o != '1) || (issue_addr_o[1:0] == 2'b00)) &&
                    (((issue_strb_o != STRB_W'(4'b0011)) &&
                      (issue_strb_o != STRB_W'(4'b1100))) || !issue_addr_o[0]));

endmodule

`default_nettype wire

/* src/apb_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface apb_if
    import lsu_pkg::*;
();
    logic [ADDR_W-1:0] paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [DATA_W-1:0] pwdata;
    logic [STRB_W-1:0] pstrb;
    logic [DATA_W-1:0] prdata;
    logic              pready;

    modport master (
        output paddr, psel, penable, pwrite, pwdata, pstrb,
        input  prdata, pready
    );

    modport slave (
        input  paddr, psel, penable, pwrite, pwdata, pstrb,
        output prdata, pready
    );

endinterface

`default_nettype wire

/* src/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    localparam int DATA_W    = 32;
    localparam int ADDR_W    = 12;
    localparam int STRB_W    = DATA_W / 8;
    localparam int RAM_WORDS = 1024;
    localparam int REG_W     = 5;

    typedef enum logic [3:0] {
        OP_LD_B,
        OP_LD_H,
        OP_LD_W,
        OP_LD_BU,
        OP_LD_HU,
        OP_ST_B,
        OP_ST_H,
        OP_ST_W
    } mem_op_e;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } apb_state_e;

    typedef struct packed {
        logic              valid;
        mem_op_e           op;
        logic [ADDR_W-1:0] addr;
        logic [REG_W-1:0]  rd;
        logic              misalign;
    } mem1_mem2_t;

    typedef struct packed {
        logic              valid;
        logic              wreg;
        logic [REG_W-1:0]  rd;
        logic [DATA_W-1:0] data;
        logic              err;
    } wb_t;

    function automatic logic op_is_load(mem_op_e op);
        return (op == OP_LD_B) || (op == OP_LD_H) || (op == OP_LD_W) ||
               (op == OP_LD_BU) || (op == OP_LD_HU);
    endfunction

endpackage

`default_nettype wire
